//--- all.f
rtl/cache_geom_pkg.sv
rtl/lce_msg_pkg.sv
rtl/mem_port_if.sv
rtl/lce_init_sweep.sv
rtl/lce_writeback.sv
rtl/lce_cmd_dispatch.sv
rtl/lce_cmd_top.sv
tb/lce_cmd_sva.sv
tb/tb_lce_cmd.sv

//--- rtl/cache_geom_pkg.sv
// geometry is fixed at 64 sets of 8 ways with 64-bit blocks and a 22-bit physical address
`default_nettype none

package cache_geom_pkg;

  localparam int SETS               = 64;
  localparam int WAYS               = 8;
  localparam int BLOCK_WIDTH        = 64;
  localparam int PADDR_WIDTH        = 22;
  localparam int BLOCK_OFFSET_WIDTH = 3;
  localparam int INDEX_WIDTH        = 6;
  localparam int WAY_WIDTH          = 3;
  // address bits above the set index
  localparam int TAG_WIDTH          = PADDR_WIDTH - INDEX_WIDTH - BLOCK_OFFSET_WIDTH;

  typedef enum logic [1:0] {
    COH_I,
    COH_S,
    COH_E,
    COH_M
  } coh_state_e;

  typedef enum logic [1:0] {
    TAG_OP_SET_CLEAR,
    TAG_OP_SET_TAG,
    TAG_OP_INVALIDATE
  } tag_op_e;

  typedef enum logic [1:0] {
    STAT_OP_SET_CLEAR,
    STAT_OP_READ,
    STAT_OP_CLEAR_DIRTY
  } stat_op_e;

  typedef struct packed {
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0]   way;
    logic [TAG_WIDTH-1:0]   tag;
    coh_state_e             state;
    tag_op_e                op;
  } tag_pkt_s;

  typedef struct packed {
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0]   way;
    stat_op_e               op;
  } stat_pkt_s;

  // data memory is only read here
  typedef struct packed {
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0]   way;
  } data_pkt_s;

  typedef struct packed {
    logic [WAYS-1:0] dirty;
  } stat_info_s;

endpackage

`default_nettype wire

//--- rtl/lce_cmd_dispatch.sv
// syncs are acked only before ready; in ready state the command input stays held until done
`default_nettype none

module lce_cmd_dispatch (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [lce_msg_pkg::LCE_ID_WIDTH-1:0] lce_id_i,
  input  lce_msg_pkg::lce_cmd_s               lce_cmd_i,
  input  logic                                lce_cmd_v_i,
  output logic                                lce_cmd_yumi_o,
  output lce_msg_pkg::lce_resp_s              lce_resp_o,
  output logic                                lce_resp_v_o,
  input  logic                                lce_resp_yumi_i,
  mem_port_if.requester                       tag_port,
  mem_port_if.requester                       stat_port,
  mem_port_if.requester                       data_port,
  output logic                                lce_ready_o,
  output logic                                set_tag_received_o,
  output logic                                set_tag_wakeup_received_o
);

  import cache_geom_pkg::*;
  import lce_msg_pkg::*;

  typedef enum logic [1:0] {
    ST_SWEEP,
    ST_SYNC,
    ST_READY
  } state_e;

  state_e                  state_r, state_n;
  logic [CCE_ID_WIDTH-1:0] sync_cnt_r, sync_cnt_n;
  logic                    inv_sent_r, inv_sent_n;

  logic      sweep_done, sweep_sel, wb_sel;
  logic      own_tag_v, own_stat_v, own_resp_v, cmd_yumi;
  tag_op_e   own_tag_op;
  tag_pkt_s  own_tag_pkt;
  stat_pkt_s own_stat_pkt;
  lce_resp_s own_resp, wb_resp;
  logic      wb_resp_v;

  mem_port_if #(.pkt_t(tag_pkt_s), .rdata_t(logic)) sweep_tag_if ();
  mem_port_if #(.pkt_t(stat_pkt_s), .rdata_t(stat_info_s)) sweep_stat_if ();
  mem_port_if #(.pkt_t(stat_pkt_s), .rdata_t(stat_info_s)) wb_stat_if ();
  mem_port_if #(.pkt_t(data_pkt_s), .rdata_t(logic [BLOCK_WIDTH-1:0])) wb_data_if ();

  lce_init_sweep i_sweep (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .tag_port (sweep_tag_if),
    .stat_port(sweep_stat_if),
    .done_o   (sweep_done)
  );

  lce_writeback i_wb (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .lce_id_i   (lce_id_i),
    .start_i    (wb_sel),
    .cmd_i      (lce_cmd_i),
    .stat_port  (wb_stat_if),
    .data_port  (wb_data_if),
    .resp_o     (wb_resp),
    .resp_v_o   (wb_resp_v),
    .resp_yumi_i(lce_resp_yumi_i)
  );

  // port owner follows the state and the pending command
  assign sweep_sel = (state_r == ST_SWEEP);
  assign wb_sel    = (state_r == ST_READY) & lce_cmd_v_i & (lce_cmd_i.msg_type == CMD_WRITEBACK);

  always_comb begin
    state_n                   = state_r;
    sync_cnt_n                = sync_cnt_r;
    inv_sent_n                = inv_sent_r;
    cmd_yumi                  = 1'b0;
    own_resp_v                = 1'b0;
    own_tag_v                 = 1'b0;
    own_tag_op                = TAG_OP_SET_CLEAR;
    own_stat_v                = 1'b0;
    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;

    if (state_r == ST_SWEEP) begin
      if (sweep_done) begin
        state_n = ST_SYNC;
      end
    end else begin
      case (lce_cmd_i.msg_type)
        CMD_SYNC: begin
          if (state_r == ST_SYNC) begin
            own_resp_v = lce_cmd_v_i;
            cmd_yumi   = lce_cmd_v_i & lce_resp_yumi_i;
            if (cmd_yumi) begin
              sync_cnt_n = sync_cnt_r + 1'b1;
              if (sync_cnt_r == CCE_ID_WIDTH'(NUM_CCE - 1)) begin
                state_n = ST_READY;
              end
            end
          end
        end
        CMD_SET_CLEAR: begin
          own_tag_v  = lce_cmd_v_i & tag_port.ready & stat_port.ready;
          own_stat_v = own_tag_v;
          cmd_yumi   = own_tag_v;
        end
        CMD_SET_TAG, CMD_SET_TAG_WAKEUP: begin
          if (state_r == ST_READY) begin
            own_tag_op = TAG_OP_SET_TAG;
            own_tag_v  = lce_cmd_v_i & tag_port.ready;
            cmd_yumi   = own_tag_v;
            set_tag_received_o        = own_tag_v & (lce_cmd_i.msg_type == CMD_SET_TAG);
            set_tag_wakeup_received_o = own_tag_v & (lce_cmd_i.msg_type == CMD_SET_TAG_WAKEUP);
          end
        end
        CMD_INVALIDATE_TAG: begin
          if (state_r == ST_READY) begin
            own_tag_op = TAG_OP_INVALIDATE;
            // one tag write, then hold the ack until taken
            own_tag_v  = lce_cmd_v_i & tag_port.ready & ~inv_sent_r;
            own_resp_v = inv_sent_r | own_tag_v;
            cmd_yumi   = own_resp_v & lce_resp_yumi_i;
            inv_sent_n = (inv_sent_r | own_tag_v) & ~cmd_yumi;
          end
        end
        CMD_WRITEBACK: begin
          cmd_yumi = wb_sel & wb_resp_v & lce_resp_yumi_i;
        end
        default: begin
          cmd_yumi = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    own_tag_pkt.index = lce_cmd_i.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
    own_tag_pkt.way   = lce_cmd_i.way;
    own_tag_pkt.tag   = lce_cmd_i.addr[BLOCK_OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
    own_tag_pkt.state = (own_tag_op == TAG_OP_SET_TAG) ? lce_cmd_i.state : COH_I;
    own_tag_pkt.op    = own_tag_op;

    own_stat_pkt.index = lce_cmd_i.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
    own_stat_pkt.way   = lce_cmd_i.way;
    own_stat_pkt.op    = STAT_OP_SET_CLEAR;

    own_resp.msg_type = (lce_cmd_i.msg_type == CMD_SYNC) ? RESP_SYNC_ACK : RESP_INV_ACK;
    own_resp.src_id   = lce_id_i;
    own_resp.dst_id   = lce_cmd_i.src_id;
    own_resp.addr     = lce_cmd_i.addr;
    own_resp.data     = '0;
  end

  assign sweep_tag_if.ready  = sweep_sel & tag_port.ready;
  assign sweep_tag_if.rdata  = tag_port.rdata;
  assign sweep_stat_if.ready = sweep_sel & stat_port.ready;
  assign sweep_stat_if.rdata = stat_port.rdata;
  assign wb_stat_if.ready    = wb_sel & stat_port.ready;
  assign wb_stat_if.rdata    = stat_port.rdata;
  assign wb_data_if.ready    = wb_sel & data_port.ready;
  assign wb_data_if.rdata    = data_port.rdata;

  assign tag_port.v    = sweep_sel ? sweep_tag_if.v : own_tag_v;
  assign tag_port.pkt  = sweep_sel ? sweep_tag_if.pkt : own_tag_pkt;
  assign stat_port.v   = sweep_sel ? sweep_stat_if.v : (wb_sel ? wb_stat_if.v : own_stat_v);
  assign stat_port.pkt = sweep_sel ? sweep_stat_if.pkt
                                   : (wb_sel ? wb_stat_if.pkt : own_stat_pkt);
  assign data_port.v   = wb_data_if.v;
  assign data_port.pkt = wb_data_if.pkt;

  assign lce_resp_v_o   = wb_sel ? wb_resp_v : own_resp_v;
  assign lce_resp_o     = wb_sel ? wb_resp : own_resp;
  assign lce_cmd_yumi_o = cmd_yumi;
  // registered sweep level, up the cycle after the last set
  assign lce_ready_o    = sweep_done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= ST_SWEEP;
      sync_cnt_r <= '0;
      inv_sent_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      sync_cnt_r <= sync_cnt_n;
      inv_sent_r <= inv_sent_n;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lce_cmd_top.sv
// plain-port wrapper; tag read data is not used and memories must return reads one cycle later
`default_nettype none

module lce_cmd_top (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [lce_msg_pkg::LCE_ID_WIDTH-1:0]    lce_id_i,
  input  lce_msg_pkg::lce_cmd_s                  lce_cmd_i,
  input  logic                                   lce_cmd_v_i,
  output logic                                   lce_cmd_yumi_o,
  output lce_msg_pkg::lce_resp_s                 lce_resp_o,
  output logic                                   lce_resp_v_o,
  input  logic                                   lce_resp_yumi_i,
  output cache_geom_pkg::tag_pkt_s               tag_pkt_o,
  output logic                                   tag_pkt_v_o,
  input  logic                                   tag_pkt_ready_i,
  output cache_geom_pkg::stat_pkt_s              stat_pkt_o,
  output logic                                   stat_pkt_v_o,
  input  logic                                   stat_pkt_ready_i,
  input  cache_geom_pkg::stat_info_s             stat_info_i,
  output cache_geom_pkg::data_pkt_s              data_pkt_o,
  output logic                                   data_pkt_v_o,
  input  logic                                   data_pkt_ready_i,
  input  logic [cache_geom_pkg::BLOCK_WIDTH-1:0] data_rd_i,
  output logic                                   lce_ready_o,
  output logic                                   set_tag_received_o,
  output logic                                   set_tag_wakeup_received_o
);

  import cache_geom_pkg::*;

  mem_port_if #(.pkt_t(tag_pkt_s), .rdata_t(logic)) tag_if ();
  mem_port_if #(.pkt_t(stat_pkt_s), .rdata_t(stat_info_s)) stat_if ();
  mem_port_if #(.pkt_t(data_pkt_s), .rdata_t(logic [BLOCK_WIDTH-1:0])) data_if ();

  assign tag_pkt_o      = tag_if.pkt;
  assign tag_pkt_v_o    = tag_if.v;
  assign tag_if.ready   = tag_pkt_ready_i;
  assign tag_if.rdata   = 1'b0;

  assign stat_pkt_o     = stat_if.pkt;
  assign stat_pkt_v_o   = stat_if.v;
  assign stat_if.ready  = stat_pkt_ready_i;
  assign stat_if.rdata  = stat_info_i;

  assign data_pkt_o     = data_if.pkt;
  assign data_pkt_v_o   = data_if.v;
  assign data_if.ready  = data_pkt_ready_i;
  assign data_if.rdata  = data_rd_i;

  lce_cmd_dispatch i_dispatch (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .lce_id_i                 (lce_id_i),
    .lce_cmd_i                (lce_cmd_i),
    .lce_cmd_v_i              (lce_cmd_v_i),
    .lce_cmd_yumi_o           (lce_cmd_yumi_o),
    .lce_resp_o               (lce_resp_o),
    .lce_resp_v_o             (lce_resp_v_o),
    .lce_resp_yumi_i          (lce_resp_yumi_i),
    .tag_port                 (tag_if),
    .stat_port                (stat_if),
    .data_port                (data_if),
    .lce_ready_o              (lce_ready_o),
    .set_tag_received_o       (set_tag_received_o),
    .set_tag_wakeup_received_o(set_tag_wakeup_received_o)
  );

endmodule

`default_nettype wire

//--- rtl/lce_init_sweep.sv
// clears one set per cycle only when tag and status memories are both ready; done holds until reset
`default_nettype none

module lce_init_sweep (
  input  logic          clk_i,
  input  logic          reset_i,
  mem_port_if.requester tag_port,
  mem_port_if.requester stat_port,
  output logic          done_o
);

  import cache_geom_pkg::*;

  logic [INDEX_WIDTH-1:0] set_cnt_r;
  logic                   done_r;
  logic                   issue;

  // both memories take the same set together
  assign issue = ~reset_i & ~done_r & tag_port.ready & stat_port.ready;

  assign tag_port.v  = issue;
  assign stat_port.v = issue;

  always_comb begin
    tag_port.pkt.index = set_cnt_r;
    tag_port.pkt.way   = '0;
    tag_port.pkt.tag   = '0;
    tag_port.pkt.state = COH_I;
    tag_port.pkt.op    = TAG_OP_SET_CLEAR;

    stat_port.pkt.index = set_cnt_r;
    stat_port.pkt.way   = '0;
    stat_port.pkt.op    = STAT_OP_SET_CLEAR;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_cnt_r <= '0;
      done_r    <= 1'b0;
    end else if (issue) begin
      set_cnt_r <= set_cnt_r + 1'b1;
      // last set accepted
      if (set_cnt_r == INDEX_WIDTH'(SETS - 1)) begin
        done_r <= 1'b1;
      end
    end
  end

  assign done_o = done_r;

endmodule

`default_nettype wire

//--- rtl/lce_msg_pkg.sv
// message formats for two directory controllers; address and way widths come from cache_geom_pkg
`default_nettype none

package lce_msg_pkg;

  localparam int NUM_CCE      = 2;
  localparam int CCE_ID_WIDTH = 1;
  localparam int LCE_ID_WIDTH = 2;

  typedef enum logic [2:0] {
    CMD_SYNC,
    CMD_SET_CLEAR,
    CMD_SET_TAG,
    CMD_SET_TAG_WAKEUP,
    CMD_INVALIDATE_TAG,
    CMD_WRITEBACK
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    RESP_SYNC_ACK,
    RESP_INV_ACK,
    RESP_WB,
    RESP_NULL_WB
  } lce_resp_type_e;

  typedef struct packed {
    lce_cmd_type_e                          msg_type;
    logic [CCE_ID_WIDTH-1:0]                src_id;
    logic [cache_geom_pkg::WAY_WIDTH-1:0]   way;
    logic [cache_geom_pkg::PADDR_WIDTH-1:0] addr;
    cache_geom_pkg::coh_state_e             state;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e                         msg_type;
    logic [LCE_ID_WIDTH-1:0]                src_id;
    logic [CCE_ID_WIDTH-1:0]                dst_id;
    logic [cache_geom_pkg::PADDR_WIDTH-1:0] addr;
    logic [cache_geom_pkg::BLOCK_WIDTH-1:0] data;
  } lce_resp_s;

endpackage

`default_nettype wire

//--- rtl/lce_writeback.sv
// cmd_i must stay stable while start_i is high; all phase flags clear when the response is consumed
`default_nettype none

module lce_writeback (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [lce_msg_pkg::LCE_ID_WIDTH-1:0] lce_id_i,
  input  logic                                start_i,
  input  lce_msg_pkg::lce_cmd_s               cmd_i,
  mem_port_if.requester                       stat_port,
  mem_port_if.requester                       data_port,
  output lce_msg_pkg::lce_resp_s              resp_o,
  output logic                                resp_v_o,
  input  logic                                resp_yumi_i
);

  import cache_geom_pkg::*;
  import lce_msg_pkg::*;

  logic [INDEX_WIDTH-1:0] index;
  logic                   stat_read_r;
  logic                   checked_r;
  logic                   data_read_r;
  logic                   buffered_r;
  logic                   cleared_r;
  logic                   dirty_r;
  logic [BLOCK_WIDTH-1:0] data_buf_r;
  logic                   stat_read_v;
  logic                   clear_v;
  logic                   done;

  assign index = cmd_i.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];

  // status read first, clear-dirty only after the block read went out
  assign stat_read_v = start_i & ~stat_read_r & stat_port.ready;
  assign clear_v     = start_i & checked_r & dirty_r & data_read_r & ~cleared_r & stat_port.ready;

  assign stat_port.v = stat_read_v | clear_v;
  assign data_port.v = start_i & checked_r & dirty_r & ~data_read_r & data_port.ready;

  always_comb begin
    stat_port.pkt.index = index;
    stat_port.pkt.way   = cmd_i.way;
    stat_port.pkt.op    = stat_read_r ? STAT_OP_CLEAR_DIRTY : STAT_OP_READ;

    data_port.pkt.index = index;
    data_port.pkt.way   = cmd_i.way;
  end

  // clean lines answer as soon as the dirty bit is known
  assign resp_v_o = start_i & checked_r & (~dirty_r | (buffered_r & cleared_r));
  assign done     = resp_v_o & resp_yumi_i;

  always_comb begin
    resp_o.msg_type = dirty_r ? RESP_WB : RESP_NULL_WB;
    resp_o.src_id   = lce_id_i;
    resp_o.dst_id   = cmd_i.src_id;
    resp_o.addr     = cmd_i.addr;
    resp_o.data     = dirty_r ? data_buf_r : '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || done) begin
      stat_read_r <= 1'b0;
      checked_r   <= 1'b0;
      data_read_r <= 1'b0;
      buffered_r  <= 1'b0;
      cleared_r   <= 1'b0;
    end else begin
      if (stat_read_v) begin
        stat_read_r <= 1'b1;
      end
      // status data arrives one cycle after the read
      if (stat_read_r & ~checked_r) begin
        checked_r <= 1'b1;
      end
      if (data_port.v) begin
        data_read_r <= 1'b1;
      end
      if (data_read_r & ~buffered_r) begin
        buffered_r <= 1'b1;
      end
      if (clear_v) begin
        cleared_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stat_read_r & ~checked_r) begin
      dirty_r <= stat_port.rdata.dirty[cmd_i.way];
    end
    if (data_read_r & ~buffered_r) begin
      data_buf_r <= data_port.rdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_port_if.sv
// requester raises v only while ready is high; rdata is valid the cycle after an accepted read
`default_nettype none

interface mem_port_if #(
  parameter type pkt_t   = logic,
  parameter type rdata_t = logic
) ();

  logic   v;
  logic   ready;
  pkt_t   pkt;
  rdata_t rdata;

  modport requester (
    output v,
    output pkt,
    input  ready,
    input  rdata
  );

  modport memory (
    input  v,
    input  pkt,
    output ready,
    output rdata
  );

endinterface

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lce_cmd -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

//--- tb/lce_cmd_sva.sv
// bound to lce_cmd_top; checks are disabled while reset is high
`default_nettype none

module lce_cmd_sva (
  input logic                      clk_i,
  input logic                      reset_i,
  input cache_geom_pkg::tag_pkt_s  tag_pkt_o,
  input logic                      tag_pkt_v_o,
  input logic                      tag_pkt_ready_i,
  input logic                      stat_pkt_v_o,
  input logic                      stat_pkt_ready_i,
  input logic                      data_pkt_v_o,
  input logic                      data_pkt_ready_i,
  input lce_msg_pkg::lce_resp_s    lce_resp_o,
  input logic                      lce_resp_v_o,
  input logic                      lce_resp_yumi_i,
  input logic                      lce_ready_o,
  input logic                      set_tag_received_o,
  input logic                      set_tag_wakeup_received_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import cache_geom_pkg::*;

  a_tag_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_o |-> tag_pkt_ready_i) else $error("tag valid without ready");
  a_stat_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    stat_pkt_v_o |-> stat_pkt_ready_i) else $error("status valid without ready");
  a_data_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_o |-> data_pkt_ready_i) else $error("data valid without ready");

  // response held until consumed
  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_resp_v_o && !lce_resp_yumi_i |=> lce_resp_v_o && $stable(lce_resp_o))
    else $error("response dropped or changed before yumi");

  // only sweep traffic before ready
  a_early: assert property (@(posedge clk_i) disable iff (reset_i)
    !lce_ready_o |-> !data_pkt_v_o && !lce_resp_v_o && !set_tag_received_o
                     && !set_tag_wakeup_received_o
                     && (!tag_pkt_v_o || tag_pkt_o.op == TAG_OP_SET_CLEAR))
    else $error("request or strobe before lce_ready_o");

endmodule

bind lce_cmd_top lce_cmd_sva i_sva (.*);

`default_nettype wire

//--- tb/tb_lce_cmd.sv
// single-process testbench; memories answer reads one cycle late under random ready and yumi
`default_nettype none

module tb_lce_cmd;

  timeunit 1ns;
  timeprecision 1ps;

  import cache_geom_pkg::*;
  import lce_msg_pkg::*;

  logic                    clk_i;
  logic                    reset_i;
  logic [LCE_ID_WIDTH-1:0] lce_id_i;
  lce_cmd_s                lce_cmd_i;
  logic                    lce_cmd_v_i;
  logic                    lce_cmd_yumi_o;
  lce_resp_s               lce_resp_o;
  logic                    lce_resp_v_o;
  logic                    lce_resp_yumi_i;
  tag_pkt_s                tag_pkt_o;
  logic                    tag_pkt_v_o;
  logic                    tag_pkt_ready_i;
  stat_pkt_s               stat_pkt_o;
  logic                    stat_pkt_v_o;
  logic                    stat_pkt_ready_i;
  stat_info_s              stat_info_i;
  data_pkt_s               data_pkt_o;
  logic                    data_pkt_v_o;
  logic                    data_pkt_ready_i;
  logic [BLOCK_WIDTH-1:0]  data_rd_i;
  logic                    lce_ready_o;
  logic                    set_tag_received_o;
  logic                    set_tag_wakeup_received_o;

  integer seed;
  integer errors;
  integer cycles;
  integer strobe_cnt;
  integer wake_cnt;
  integer data_cnt;
  logic   hold_ready;
  logic   reset_nxt;
  logic   cmd_v_nxt;
  logic   cmd_taken;
  logic   stat_rd_seen;
  logic   data_rd_seen;
  lce_cmd_s cmd_nxt;
  data_pkt_s data_rd_pkt;
  logic [INDEX_WIDTH-1:0] stat_rd_idx;
  logic [WAYS-1:0]        dirty_m [SETS];
  logic [BLOCK_WIDTH-1:0] data_salt;
  tag_pkt_s  tag_q [$];
  stat_pkt_s stat_q [$];
  lce_resp_s resp_q [$];

  lce_cmd_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // block contents follow index and way
  function automatic logic [BLOCK_WIDTH-1:0] block_of(logic [INDEX_WIDTH-1:0] idx,
                                                      logic [WAY_WIDTH-1:0] way);
    return data_salt ^ {23'd0, idx, way, idx, way, 23'd0};
  endfunction

  // memory side of the model, seen from stable values
  task automatic sample();
    cmd_taken    = lce_cmd_v_i & lce_cmd_yumi_o;
    stat_rd_seen = 1'b0;
    data_rd_seen = 1'b0;
    if (tag_pkt_v_o && tag_pkt_ready_i) begin
      tag_q.push_back(tag_pkt_o);
    end
    if (stat_pkt_v_o && stat_pkt_ready_i) begin
      stat_q.push_back(stat_pkt_o);
      case (stat_pkt_o.op)
        STAT_OP_SET_CLEAR: dirty_m[stat_pkt_o.index] = '0;
        STAT_OP_CLEAR_DIRTY: dirty_m[stat_pkt_o.index][stat_pkt_o.way] = 1'b0;
        default: begin
          stat_rd_seen = 1'b1;
          stat_rd_idx  = stat_pkt_o.index;
        end
      endcase
    end
    if (data_pkt_v_o && data_pkt_ready_i) begin
      data_rd_seen = 1'b1;
      data_rd_pkt  = data_pkt_o;
      data_cnt++;
    end
    if (lce_resp_v_o && lce_resp_yumi_i) begin
      resp_q.push_back(lce_resp_o);
    end
    strobe_cnt += int'(set_tag_received_o);
    wake_cnt   += int'(set_tag_wakeup_received_o);
  endtask

  // drive on the rising edge, observe on the falling edge
  task automatic tick();
    @(posedge clk_i);
    reset_i          <= reset_nxt;
    lce_cmd_i        <= cmd_nxt;
    lce_cmd_v_i      <= cmd_v_nxt;
    tag_pkt_ready_i  <= hold_ready | (($random(seed) & 3) != 0);
    stat_pkt_ready_i <= hold_ready | (($random(seed) & 3) != 0);
    data_pkt_ready_i <= hold_ready | (($random(seed) & 3) != 0);
    lce_resp_yumi_i  <= hold_ready | (($random(seed) & 1) != 0);
    if (stat_rd_seen) begin
      stat_info_i <= dirty_m[stat_rd_idx];
    end
    if (data_rd_seen) begin
      data_rd_i <= block_of(data_rd_pkt.index, data_rd_pkt.way);
    end
    @(negedge clk_i);
    sample();
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(logic cond, string what);
    assert (cond) else begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic clear_log();
    tag_q.delete();
    stat_q.delete();
    resp_q.delete();
    strobe_cnt = 0;
    wake_cnt   = 0;
    data_cnt   = 0;
  endtask

  task automatic send_cmd(lce_cmd_s c);
    integer t;
    cmd_nxt   = c;
    cmd_v_nxt = 1'b1;
    t = 0;
    do begin
      tick();
      t++;
    end while (!cmd_taken && t < 300);
    check_true(cmd_taken, "command was not consumed before timeout");
    cmd_v_nxt = 1'b0;
  endtask

  task automatic check_resp(lce_resp_type_e typ, lce_cmd_s c, logic [BLOCK_WIDTH-1:0] data);
    check_val("resp count", 64'(resp_q.size()), 64'd1);
    if (resp_q.size() == 1) begin
      check_val("lce_resp_o.msg_type", 64'(resp_q[0].msg_type), 64'(typ));
      check_val("lce_resp_o.src_id", 64'(resp_q[0].src_id), 64'(lce_id_i));
      check_val("lce_resp_o.dst_id", 64'(resp_q[0].dst_id), 64'(c.src_id));
      if (typ != RESP_SYNC_ACK) begin
        check_val("lce_resp_o.addr", 64'(resp_q[0].addr), 64'(c.addr));
        check_val("lce_resp_o.data", resp_q[0].data, data);
      end
    end
  endtask

  task automatic run_random_cmd();
    lce_cmd_s c;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   dirty;
    c.msg_type = lce_cmd_type_e'(($unsigned($random(seed)) % 5) + 1);
    c.src_id   = CCE_ID_WIDTH'($random(seed));
    c.way      = WAY_WIDTH'($random(seed));
    c.addr     = PADDR_WIDTH'($random(seed));
    c.state    = coh_state_e'($random(seed) & 3);
    idx   = c.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
    tag   = c.addr[BLOCK_OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
    dirty = dirty_m[idx][c.way];
    clear_log();
    send_cmd(c);
    case (c.msg_type)
      CMD_SET_CLEAR: begin
        check_val("tag requests", 64'(tag_q.size()), 64'd1);
        check_val("stat requests", 64'(stat_q.size()), 64'd1);
        check_val("resp count", 64'(resp_q.size()), 64'd0);
        if (tag_q.size() == 1 && stat_q.size() == 1) begin
          check_val("tag_pkt_o.op", 64'(tag_q[0].op), 64'(TAG_OP_SET_CLEAR));
          check_val("tag_pkt_o.index", 64'(tag_q[0].index), 64'(idx));
          check_val("stat_pkt_o.op", 64'(stat_q[0].op), 64'(STAT_OP_SET_CLEAR));
          check_val("stat_pkt_o.index", 64'(stat_q[0].index), 64'(idx));
        end
      end
      CMD_SET_TAG, CMD_SET_TAG_WAKEUP: begin
        check_val("tag requests", 64'(tag_q.size()), 64'd1);
        check_val("resp count", 64'(resp_q.size()), 64'd0);
        if (tag_q.size() == 1) begin
          check_val("tag_pkt_o.op", 64'(tag_q[0].op), 64'(TAG_OP_SET_TAG));
          check_val("tag_pkt_o.index", 64'(tag_q[0].index), 64'(idx));
          check_val("tag_pkt_o.way", 64'(tag_q[0].way), 64'(c.way));
          check_val("tag_pkt_o.tag", 64'(tag_q[0].tag), 64'(tag));
          check_val("tag_pkt_o.state", 64'(tag_q[0].state), 64'(c.state));
        end
        check_val("set_tag_received_o pulses", 64'(strobe_cnt),
                  64'(c.msg_type == CMD_SET_TAG));
        check_val("set_tag_wakeup_received_o pulses", 64'(wake_cnt),
                  64'(c.msg_type == CMD_SET_TAG_WAKEUP));
      end
      CMD_INVALIDATE_TAG: begin
        check_val("tag requests", 64'(tag_q.size()), 64'd1);
        if (tag_q.size() == 1) begin
          check_val("tag_pkt_o.op", 64'(tag_q[0].op), 64'(TAG_OP_INVALIDATE));
          check_val("tag_pkt_o.index", 64'(tag_q[0].index), 64'(idx));
          check_val("tag_pkt_o.way", 64'(tag_q[0].way), 64'(c.way));
        end
        check_resp(RESP_INV_ACK, c, '0);
      end
      default: begin
        // writeback reads status, then block and clear-dirty only for a dirty line
        check_val("stat requests", 64'(stat_q.size()), dirty ? 64'd2 : 64'd1);
        check_val("data reads", 64'(data_cnt), 64'(dirty));
        if (stat_q.size() > 0) begin
          check_val("stat_pkt_o.op", 64'(stat_q[0].op), 64'(STAT_OP_READ));
          check_val("stat_pkt_o.index", 64'(stat_q[0].index), 64'(idx));
          check_val("stat_pkt_o.way", 64'(stat_q[0].way), 64'(c.way));
        end
        if (dirty && stat_q.size() == 2) begin
          check_val("stat_pkt_o.op", 64'(stat_q[1].op), 64'(STAT_OP_CLEAR_DIRTY));
          check_val("stat_pkt_o.index", 64'(stat_q[1].index), 64'(idx));
          check_val("stat_pkt_o.way", 64'(stat_q[1].way), 64'(c.way));
        end
        if (dirty && data_cnt == 1) begin
          check_val("data_pkt_o.index", 64'(data_rd_pkt.index), 64'(idx));
          check_val("data_pkt_o.way", 64'(data_rd_pkt.way), 64'(c.way));
        end
        check_resp(dirty ? RESP_WB : RESP_NULL_WB, c, dirty ? block_of(idx, c.way) : '0);
      end
    endcase
    if (c.msg_type != CMD_SET_TAG && c.msg_type != CMD_SET_TAG_WAKEUP) begin
      check_val("received strobe pulses", 64'(strobe_cnt + wake_cnt), 64'd0);
    end
  endtask

  initial begin
    lce_cmd_s c;
    seed = 32'h03528581;
    errors = 0;
    reset_i = 1'b1;
    reset_nxt = 1'b1;
    lce_id_i = 2'd2;
    lce_cmd_i = '0;
    lce_cmd_v_i = 1'b0;
    cmd_nxt = '0;
    cmd_v_nxt = 1'b0;
    lce_resp_yumi_i = 1'b1;
    tag_pkt_ready_i = 1'b1;
    stat_pkt_ready_i = 1'b1;
    data_pkt_ready_i = 1'b1;
    stat_info_i = '0;
    data_rd_i = '0;
    hold_ready = 1'b1;
    stat_rd_seen = 1'b0;
    data_rd_seen = 1'b0;
    clear_log();
    repeat (10) tick();

    // sweep timing with every port ready
    reset_nxt = 1'b0;
    cycles = 0;
    tick();
    while (!lce_ready_o && cycles < 4 * SETS) begin
      cycles++;
      tick();
    end
    check_val("lce_ready_o delay", 64'(cycles), 64'(SETS));
    check_val("sweep tag requests", 64'(tag_q.size()), 64'(SETS));
    check_val("sweep stat requests", 64'(stat_q.size()), 64'(SETS));
    for (int i = 0; i < SETS && i < tag_q.size() && i < stat_q.size(); i++) begin
      check_val("tag_pkt_o.index", 64'(tag_q[i].index), 64'(i));
      check_val("tag_pkt_o.op", 64'(tag_q[i].op), 64'(TAG_OP_SET_CLEAR));
      check_val("stat_pkt_o.index", 64'(stat_q[i].index), 64'(i));
      check_val("stat_pkt_o.op", 64'(stat_q[i].op), 64'(STAT_OP_SET_CLEAR));
    end

    // cache contents from earlier traffic
    for (int i = 0; i < SETS; i++) begin
      dirty_m[i] = WAYS'($random(seed));
    end
    data_salt = {$random(seed), $random(seed)};
    hold_ready = 1'b0;

    for (int s = 0; s < NUM_CCE; s++) begin
      if (s == NUM_CCE - 1) begin
        // set-tag must wait for the last sync
        clear_log();
        cmd_nxt = '0;
        cmd_nxt.msg_type = CMD_SET_TAG;
        cmd_v_nxt = 1'b1;
        repeat (20) begin
          tick();
          check_true(!cmd_taken, "set-tag consumed before the last sync");
        end
        check_val("early tag requests", 64'(tag_q.size()), 64'd0);
        cmd_v_nxt = 1'b0;
        tick();
      end
      c = '0;
      c.msg_type = CMD_SYNC;
      c.src_id = CCE_ID_WIDTH'(s);
      clear_log();
      send_cmd(c);
      check_resp(RESP_SYNC_ACK, c, '0);
    end

    repeat (80) run_random_cmd();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
